//--- hdl/lane_mgr_cfg.svh
`ifndef LANE_MGR_CFG_SVH
`define LANE_MGR_CFG_SVH

// Link size
`define LM_NUM_LANES            8

// Retry limits per lane
`define LM_MAX_TRAIN_ATTEMPTS   8'd10
`define LM_MAX_REPAIR_ATTEMPTS  8'd5

// Margin over quality threshold to leave marginal
`define LM_MARGINAL_HYSTERESIS  8'd20

// Temperatures in degrees
`define LM_TEMP_CRITICAL        8'd110
`define LM_TEMP_NORMAL          8'd85

// Signal quality breakpoints
`define LM_QUAL_EXCELLENT       8'd200
`define LM_QUAL_LOW_ERRORS      16'd10
`define LM_QUAL_GOOD            8'd150

// Quality score codes
`define LM_GRADE_EXCELLENT      8'hFF
`define LM_GRADE_GOOD           8'hC0
`define LM_GRADE_OK             8'h80
`define LM_GRADE_POOR           8'h40

// Statistics counter width
`define LM_CNT_W                16

`endif

//--- hdl/lane_mgr_pkg.sv
package lane_mgr_pkg;

    typedef enum logic [2:0] {
        LANE_DISABLED    = 3'd0,
        LANE_TRAINING    = 3'd1,
        LANE_ACTIVE      = 3'd2,
        LANE_ERROR       = 3'd3,
        LANE_REPAIR      = 3'd4,
        LANE_MARGINAL    = 3'd5,
        LANE_THERMAL_OFF = 3'd6
    } lane_state_t;

    // Degrees
    typedef logic [7:0] temperature_t;

    // Per-lane status reported by the PHY
    typedef struct packed {
        logic         ready;
        logic         error;
        logic         trained;
        logic         throttle;
        logic [7:0]   signal_quality;
        logic [15:0]  error_count;
        temperature_t temperature;
    } phy_lane_status_t;

    // Link-wide settings
    typedef struct packed {
        logic         repair_enable;
        logic [7:0]   repair_threshold_errors;
        logic [15:0]  repair_timeout_cycles;
        logic [7:0]   quality_threshold;
    } lane_policy_t;

    typedef struct packed {
        logic         lane_enable;
        logic         lane_reset;
        logic         repair_active;
        logic         repaired;
        logic         degraded;
        logic         marginal;
        logic         thermal_disable;
        logic [7:0]   quality_score;
    } lane_ctrl_t;

    // Single-cycle pulses, high in the first cycle of a new state
    typedef struct packed {
        logic         changed;
        logic         entered_training;
        logic         trained_ok;
        logic         entered_repair;
    } lane_event_t;

endpackage

//--- hdl/lane_fsm.sv
`include "lane_mgr_cfg.svh"

module lane_fsm #(
    parameter int LANE_ID = 0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           lane_mgmt_enable,
    input  logic [7:0]                     target_lane_count,
    input  lane_mgr_pkg::phy_lane_status_t status,
    input  lane_mgr_pkg::lane_policy_t     policy,
    output lane_mgr_pkg::lane_ctrl_t       ctrl,
    output lane_mgr_pkg::lane_state_t      state,
    output lane_mgr_pkg::lane_event_t      lane_event
);

    import lane_mgr_pkg::*;

    lane_state_t state_nxt;
    logic [7:0]  train_cnt;
    logic [7:0]  repair_cnt;
    logic [15:0] repair_timer;
    logic        repaired;
    logic [7:0]  grade;
    logic [7:0]  grade_nxt;
    logic [8:0]  recover_level;
    logic        over_errors;
    logic        enter_training;
    logic        enter_repair;
    logic        repair_done;

    assign over_errors   = status.error_count > {8'd0, policy.repair_threshold_errors};
    assign recover_level = {1'b0, policy.quality_threshold} + {1'b0, `LM_MARGINAL_HYSTERESIS};

    always_comb begin
        state_nxt = state;
        case (state)
            LANE_DISABLED: begin
                if (8'(LANE_ID) < target_lane_count) begin
                    state_nxt = LANE_TRAINING;
                end
            end
            LANE_TRAINING: begin
                // Give up after too many training entries
                if (train_cnt > `LM_MAX_TRAIN_ATTEMPTS) begin
                    state_nxt = LANE_ERROR;
                end else if (status.trained && status.ready) begin
                    state_nxt = LANE_ACTIVE;
                end else if (status.error) begin
                    state_nxt = LANE_ERROR;
                end
            end
            LANE_ACTIVE: begin
                if (status.error) begin
                    state_nxt = LANE_ERROR;
                end else if (status.throttle || (status.temperature > `LM_TEMP_CRITICAL)) begin
                    state_nxt = LANE_THERMAL_OFF;
                end else if (status.signal_quality < policy.quality_threshold) begin
                    state_nxt = LANE_MARGINAL;
                end else if (over_errors) begin
                    state_nxt = policy.repair_enable ? LANE_REPAIR : LANE_ERROR;
                end
            end
            LANE_ERROR: begin
                if (policy.repair_enable && (repair_cnt < `LM_MAX_REPAIR_ATTEMPTS)) begin
                    state_nxt = LANE_REPAIR;
                end else begin
                    state_nxt = LANE_DISABLED;
                end
            end
            LANE_REPAIR: begin
                if (repair_timer == '0) begin
                    state_nxt = (status.ready && !status.error) ? LANE_TRAINING : LANE_ERROR;
                end
            end
            LANE_MARGINAL: begin
                if ({1'b0, status.signal_quality} > recover_level) begin
                    state_nxt = LANE_ACTIVE;
                end else if (status.error || over_errors) begin
                    state_nxt = LANE_ERROR;
                end
            end
            LANE_THERMAL_OFF: begin
                if (!status.throttle && (status.temperature < `LM_TEMP_NORMAL)) begin
                    state_nxt = LANE_TRAINING;
                end
            end
            default: begin
                state_nxt = LANE_DISABLED;
            end
        endcase
    end

    assign enter_training = (state_nxt == LANE_TRAINING) && (state != LANE_TRAINING);
    assign enter_repair   = (state_nxt == LANE_REPAIR) && (state != LANE_REPAIR);
    assign repair_done    = (state == LANE_REPAIR) && (repair_timer == '0);

    // Quality grade from the PHY quality and error count
    always_comb begin
        if ((status.signal_quality > `LM_QUAL_EXCELLENT) &&
            (status.error_count < `LM_QUAL_LOW_ERRORS)) begin
            grade_nxt = `LM_GRADE_EXCELLENT;
        end else if (status.signal_quality > `LM_QUAL_GOOD) begin
            grade_nxt = `LM_GRADE_GOOD;
        end else if (status.signal_quality > policy.quality_threshold) begin
            grade_nxt = `LM_GRADE_OK;
        end else begin
            grade_nxt = `LM_GRADE_POOR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LANE_DISABLED;
            lane_event   <= '0;
            train_cnt    <= '0;
            repair_cnt   <= '0;
            repair_timer <= '0;
            repaired     <= 1'b0;
            grade        <= `LM_GRADE_OK;
        end else if (lane_mgmt_enable) begin
            state                       <= state_nxt;
            lane_event.changed          <= state_nxt != state;
            lane_event.entered_training <= enter_training;
            lane_event.trained_ok       <= (state == LANE_TRAINING) && (state_nxt == LANE_ACTIVE);
            lane_event.entered_repair   <= enter_repair;
            grade                       <= grade_nxt;

            // Saturate so a stuck lane stays failed
            if (enter_training && (train_cnt != 8'hFF)) begin
                train_cnt <= train_cnt + 8'd1;
            end
            if (enter_repair && (repair_cnt != 8'hFF)) begin
                repair_cnt <= repair_cnt + 8'd1;
            end

            if (enter_repair) begin
                repair_timer <= policy.repair_timeout_cycles;
            end else if ((state == LANE_REPAIR) && (repair_timer != '0)) begin
                repair_timer <= repair_timer - 16'd1;
            end

            if (repair_done) begin
                repaired <= state_nxt == LANE_TRAINING;
            end
        end else begin
            lane_event <= '0;
        end
    end

    always_comb begin
        ctrl.lane_enable     = (state == LANE_TRAINING) || (state == LANE_ACTIVE) ||
                               (state == LANE_REPAIR) || (state == LANE_MARGINAL);
        ctrl.lane_reset      = (state == LANE_REPAIR) || lane_event.entered_training;
        ctrl.repair_active   = state == LANE_REPAIR;
        ctrl.repaired        = repaired;
        ctrl.degraded        = (state == LANE_ERROR) || (state == LANE_MARGINAL);
        ctrl.marginal        = state == LANE_MARGINAL;
        ctrl.thermal_disable = state == LANE_THERMAL_OFF;
        ctrl.quality_score   = grade;
    end

endmodule

//--- hdl/lane_stats.sv
`include "lane_mgr_cfg.svh"

module lane_stats (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  lane_mgr_pkg::lane_event_t [`LM_NUM_LANES-1:0] lane_event,
    output logic [`LM_CNT_W-1:0]                          lane_transition_count,
    output logic [`LM_CNT_W-1:0]                          training_attempt_count,
    output logic [`LM_CNT_W-1:0]                          training_success_count,
    output logic [`LM_CNT_W-1:0]                          repair_operation_count,
    output logic [7:0]                                    training_success_rate
);

    // Room for success count times 100
    localparam int RATE_W = `LM_CNT_W + 7;

    logic [`LM_CNT_W-1:0] transition_inc;
    logic [`LM_CNT_W-1:0] attempt_inc;
    logic [`LM_CNT_W-1:0] success_inc;
    logic [`LM_CNT_W-1:0] repair_inc;
    logic [RATE_W-1:0]    success_scaled;
    logic [RATE_W-1:0]    rate_full;

    // Number of lanes raising each pulse this cycle
    always_comb begin
        transition_inc = '0;
        attempt_inc    = '0;
        success_inc    = '0;
        repair_inc     = '0;
        for (int i = 0; i < `LM_NUM_LANES; i++) begin
            transition_inc = transition_inc + `LM_CNT_W'(lane_event[i].changed);
            attempt_inc    = attempt_inc + `LM_CNT_W'(lane_event[i].entered_training);
            success_inc    = success_inc + `LM_CNT_W'(lane_event[i].trained_ok);
            repair_inc     = repair_inc + `LM_CNT_W'(lane_event[i].entered_repair);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_transition_count  <= '0;
            training_attempt_count <= '0;
            training_success_count <= '0;
            repair_operation_count <= '0;
        end else begin
            lane_transition_count  <= lane_transition_count + transition_inc;
            training_attempt_count <= training_attempt_count + attempt_inc;
            training_success_count <= training_success_count + success_inc;
            repair_operation_count <= repair_operation_count + repair_inc;
        end
    end

    assign success_scaled = RATE_W'(training_success_count) * RATE_W'(100);

    // Percentage, truncated
    always_comb begin
        if (training_attempt_count == '0) begin
            rate_full = '0;
        end else begin
            rate_full = success_scaled / RATE_W'(training_attempt_count);
        end
    end

    assign training_success_rate = rate_full[7:0];

endmodule

//--- hdl/link_health.sv
`include "lane_mgr_cfg.svh"

module link_health (
    input  lane_mgr_pkg::lane_state_t [`LM_NUM_LANES-1:0] state,
    input  logic [7:0]                                    target_lane_count,
    input  logic [7:0]                                    min_lane_count,
    output logic [7:0]                                    active_lane_count,
    output logic [7:0]                                    failed_lane_count,
    output logic                                          link_degradation_alarm
);

    import lane_mgr_pkg::*;

    logic [7:0] active_sum;
    logic [7:0] failed_sum;
    logic [7:0] failed_limit;

    always_comb begin
        active_sum = '0;
        failed_sum = '0;
        for (int i = 0; i < `LM_NUM_LANES; i++) begin
            if (state[i] == LANE_ACTIVE) begin
                active_sum = active_sum + 8'd1;
            end
            // Disabled lanes count as lost bandwidth too
            if ((state[i] == LANE_ERROR) || (state[i] == LANE_DISABLED)) begin
                failed_sum = failed_sum + 8'd1;
            end
        end
    end

    // A quarter of the target, rounded down
    assign failed_limit = target_lane_count >> 2;

    assign active_lane_count      = active_sum;
    assign failed_lane_count      = failed_sum;
    assign link_degradation_alarm = (active_sum < min_lane_count) ||
                                    (failed_sum > failed_limit);

endmodule

//--- hdl/lane_manager.sv
`include "lane_mgr_cfg.svh"

module lane_manager (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               lane_mgmt_enable,
    input  logic [7:0]                                         target_lane_count,
    input  logic [7:0]                                         min_lane_count,
    input  lane_mgr_pkg::phy_lane_status_t [`LM_NUM_LANES-1:0] phy_status,
    input  lane_mgr_pkg::lane_policy_t                         policy,
    output lane_mgr_pkg::lane_ctrl_t [`LM_NUM_LANES-1:0]       lane_ctrl,
    output logic [7:0]                                         active_lane_count,
    output logic [7:0]                                         failed_lane_count,
    output logic                                               link_degradation_alarm,
    output logic [`LM_CNT_W-1:0]                               lane_transition_count,
    output logic [`LM_CNT_W-1:0]                               training_attempt_count,
    output logic [`LM_CNT_W-1:0]                               training_success_count,
    output logic [`LM_CNT_W-1:0]                               repair_operation_count,
    output logic [7:0]                                         training_success_rate
);

    import lane_mgr_pkg::*;

    lane_state_t [`LM_NUM_LANES-1:0] lane_state;
    lane_event_t [`LM_NUM_LANES-1:0] lane_event;

    // One state machine per physical lane
    for (genvar i = 0; i < `LM_NUM_LANES; i++) begin : gen_lane
        lane_fsm #(
            .LANE_ID (i)
        ) lane_fsm_i (
            .clk               (clk),
            .rst_n             (rst_n),
            .lane_mgmt_enable  (lane_mgmt_enable),
            .target_lane_count (target_lane_count),
            .status            (phy_status[i]),
            .policy            (policy),
            .ctrl              (lane_ctrl[i]),
            .state             (lane_state[i]),
            .lane_event        (lane_event[i])
        );
    end

    lane_stats lane_stats_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .lane_event             (lane_event),
        .lane_transition_count  (lane_transition_count),
        .training_attempt_count (training_attempt_count),
        .training_success_count (training_success_count),
        .repair_operation_count (repair_operation_count),
        .training_success_rate  (training_success_rate)
    );

    link_health link_health_i (
        .state                  (lane_state),
        .target_lane_count      (target_lane_count),
        .min_lane_count         (min_lane_count),
        .active_lane_count      (active_lane_count),
        .failed_lane_count      (failed_lane_count),
        .link_degradation_alarm (link_degradation_alarm)
    );

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held low for four clock periods
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- bench/lane_manager_checker.sv
`include "lane_mgr_cfg.svh"

module lane_manager_checker (
    input  logic                                         clk,
    input  logic                                         check_valid,
    input  int                                           check_row,
    input  logic [2:0]                                   watch_lane,
    input  lane_mgr_pkg::lane_ctrl_t                     exp_ctrl,
    input  logic [7:0]                                   exp_active,
    input  logic [7:0]                                   exp_failed,
    input  logic                                         exp_alarm,
    input  logic [`LM_CNT_W-1:0]                         exp_trans,
    input  logic [`LM_CNT_W-1:0]                         exp_attempts,
    input  logic [`LM_CNT_W-1:0]                         exp_success,
    input  logic [`LM_CNT_W-1:0]                         exp_repairs,
    input  logic [7:0]                                   exp_rate,
    input  lane_mgr_pkg::lane_ctrl_t [`LM_NUM_LANES-1:0] lane_ctrl,
    input  logic [7:0]                                   active_lane_count,
    input  logic [7:0]                                   failed_lane_count,
    input  logic                                         link_degradation_alarm,
    input  logic [`LM_CNT_W-1:0]                         lane_transition_count,
    input  logic [`LM_CNT_W-1:0]                         training_attempt_count,
    input  logic [`LM_CNT_W-1:0]                         training_success_count,
    input  logic [`LM_CNT_W-1:0]                         repair_operation_count,
    input  logic [7:0]                                   training_success_rate,
    output int                                           rows_done,
    output int                                           error_total
);

    int row_errs;
    int rows_failed;

    initial begin
        rows_done   = 0;
        error_total = 0;
        rows_failed = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("** Error row %0d %s exp %h got %h", check_row, name, exp, got);
            row_errs++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (check_valid) begin
            row_errs = 0;
            compare($sformatf("lane_ctrl[%0d]", watch_lane), 32'(exp_ctrl),
                    32'(lane_ctrl[watch_lane]));
            compare("active_lane_count", 32'(exp_active), 32'(active_lane_count));
            compare("failed_lane_count", 32'(exp_failed), 32'(failed_lane_count));
            compare("link_degradation_alarm", 32'(exp_alarm), 32'(link_degradation_alarm));
            compare("lane_transition_count", 32'(exp_trans), 32'(lane_transition_count));
            compare("training_attempt_count", 32'(exp_attempts), 32'(training_attempt_count));
            compare("training_success_count", 32'(exp_success), 32'(training_success_count));
            compare("repair_operation_count", 32'(exp_repairs), 32'(repair_operation_count));
            compare("training_success_rate", 32'(exp_rate), 32'(training_success_rate));
            if (row_errs == 0) begin
                $display("row %0d: ok", check_row);
            end else begin
                $display("row %0d: %0d mismatches", check_row, row_errs);
                rows_failed++;
            end
            error_total = error_total + row_errs;
            rows_done++;
        end
    end

    task automatic print_summary();
        $display("rows checked %0d, rows failed %0d, mismatches %0d",
                 rows_done, rows_failed, error_total);
    endtask

endmodule

//--- bench/lane_manager_tb.sv
`include "lane_mgr_cfg.svh"

module lane_manager_tb;

    import lane_mgr_pkg::*;

    typedef struct packed {
        logic                 enable;
        logic [7:0]           target;
        logic [7:0]           min_lanes;
        logic [7:0]           alt_mask;
        phy_lane_status_t     alt_status;
        lane_policy_t         policy;
        logic [7:0]           hold;
        logic [2:0]           watch;
        lane_ctrl_t           ctrl;
        logic [7:0]           active;
        logic [7:0]           failed;
        logic                 alarm;
        logic [`LM_CNT_W-1:0] trans;
        logic [`LM_CNT_W-1:0] attempts;
        logic [`LM_CNT_W-1:0] success;
        logic [`LM_CNT_W-1:0] repairs;
        logic [7:0]           rate;
    } step_t;

    logic clk;
    logic rst_n;
    logic lane_mgmt_enable;
    logic [7:0] target_lane_count;
    logic [7:0] min_lane_count;
    phy_lane_status_t [`LM_NUM_LANES-1:0] phy_status;
    lane_policy_t policy;
    lane_ctrl_t [`LM_NUM_LANES-1:0] lane_ctrl;
    logic [7:0] active_lane_count;
    logic [7:0] failed_lane_count;
    logic link_degradation_alarm;
    logic [`LM_CNT_W-1:0] lane_transition_count;
    logic [`LM_CNT_W-1:0] training_attempt_count;
    logic [`LM_CNT_W-1:0] training_success_count;
    logic [`LM_CNT_W-1:0] repair_operation_count;
    logic [7:0] training_success_rate;

    logic check_valid;
    int check_row;
    step_t exp_step;
    int rows_done;
    int error_total;
    logic timed_out;
    step_t steps[$];
    phy_lane_status_t base_status;
    lane_policy_t repair_on;
    lane_policy_t repair_off;

    tb_clock_gen tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

    lane_manager lane_manager_i (.*);

    lane_manager_checker lane_manager_checker_i (
        .clk(clk), .check_valid(check_valid), .check_row(check_row),
        .watch_lane(exp_step.watch), .exp_ctrl(exp_step.ctrl),
        .exp_active(exp_step.active), .exp_failed(exp_step.failed),
        .exp_alarm(exp_step.alarm), .exp_trans(exp_step.trans),
        .exp_attempts(exp_step.attempts), .exp_success(exp_step.success),
        .exp_repairs(exp_step.repairs), .exp_rate(exp_step.rate),
        .lane_ctrl(lane_ctrl), .active_lane_count(active_lane_count),
        .failed_lane_count(failed_lane_count),
        .link_degradation_alarm(link_degradation_alarm),
        .lane_transition_count(lane_transition_count),
        .training_attempt_count(training_attempt_count),
        .training_success_count(training_success_count),
        .repair_operation_count(repair_operation_count),
        .training_success_rate(training_success_rate),
        .rows_done(rows_done), .error_total(error_total)
    );

    function automatic phy_lane_status_t lane_status(logic error, logic throttle,
                                                     logic [7:0] quality, logic [15:0] errors);
        phy_lane_status_t s;
        s.ready          = 1'b1;
        s.error          = error;
        s.trained        = 1'b1;
        s.throttle       = throttle;
        s.signal_quality = quality;
        s.error_count    = errors;
        s.temperature    = 8'd50;
        return s;
    endfunction

    task automatic add_step(logic en, logic [7:0] tgt, logic [7:0] mn, logic [7:0] mask,
                            phy_lane_status_t alt, lane_policy_t pol, logic [7:0] hold,
                            logic [2:0] watch, logic [14:0] ctrl, logic [7:0] act,
                            logic [7:0] fail, logic alarm, int trans, int att, int succ,
                            int rep, logic [7:0] rate);
        step_t s;
        s = '{en, tgt, mn, mask, alt, pol, hold, watch, lane_ctrl_t'(ctrl), act, fail, alarm,
              `LM_CNT_W'(trans), `LM_CNT_W'(att), `LM_CNT_W'(succ), `LM_CNT_W'(rep), rate};
        steps.push_back(s);
    endtask

    task automatic apply_step(input step_t s);
        lane_mgmt_enable  <= s.enable;
        target_lane_count <= s.target;
        min_lane_count    <= s.min_lanes;
        policy            <= s.policy;
        for (int i = 0; i < `LM_NUM_LANES; i++) begin
            phy_status[i] <= s.alt_mask[i] ? s.alt_status : base_status;
        end
    endtask

    initial begin
        base_status = lane_status(1'b0, 1'b0, 8'd210, 16'd0);
        repair_on   = lane_policy_t'({1'b1, 8'd20, 16'd3, 8'd100});
        repair_off  = lane_policy_t'({1'b0, 8'd20, 16'd3, 8'd100});
        lane_mgmt_enable  = 1'b0;
        target_lane_count = 8'd32;
        min_lane_count    = 8'd0;
        policy            = repair_on;
        phy_status        = {`LM_NUM_LANES{base_status}};
        check_valid       = 1'b0;
        check_row         = 0;
        exp_step          = '0;
        timed_out         = 1'b0;

        // Columns: en tgt min mask alt policy hold lane ctrl act fail alarm trans att succ rep rate
        add_step(0, 32, 0, 8'h00, base_status, repair_on, 1, 0, {7'b0000000, 8'h80},
                 0, 8, 0, 0, 0, 0, 0, 0);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 1, 0, {7'b1100000, 8'hFF},
                 0, 2, 1, 0, 0, 0, 0, 0);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 1, 0, {7'b1000000, 8'hFF},
                 6, 2, 1, 12, 6, 6, 0, 100);
        add_step(1, 6, 0, 8'h04, lane_status(0, 0, 8'h50, 0), repair_on, 1, 2,
                 {7'b1000110, 8'h40}, 5, 2, 1, 12, 6, 6, 0, 100);
        add_step(1, 6, 0, 8'h04, lane_status(0, 0, 8'h79, 0), repair_on, 1, 2,
                 {7'b1000000, 8'h80}, 6, 2, 1, 13, 6, 6, 0, 100);
        add_step(1, 6, 0, 8'h08, lane_status(0, 0, 8'd210, 16'h15), repair_on, 1, 3,
                 {7'b1110000, 8'hC0}, 5, 2, 1, 14, 6, 6, 0, 100);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 2, 3, {7'b1110000, 8'hFF},
                 5, 2, 1, 15, 6, 6, 1, 100);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 1, 3, {7'b1001000, 8'hFF},
                 6, 2, 1, 16, 7, 6, 1, 85);
        add_step(1, 6, 0, 8'h02, lane_status(0, 1, 8'd210, 0), repair_on, 1, 1,
                 {7'b0000001, 8'hFF}, 5, 2, 1, 17, 7, 7, 1, 100);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 1, 1, {7'b1100000, 8'hFF},
                 5, 2, 1, 18, 7, 7, 1, 100);
        add_step(1, 6, 0, 8'h00, base_status, repair_on, 1, 1, {7'b1000000, 8'hFF},
                 6, 2, 1, 20, 8, 8, 1, 100);
        add_step(1, 6, 6, 8'h30, lane_status(1, 0, 8'd210, 0), repair_off, 1, 4,
                 {7'b0000100, 8'hFF}, 4, 4, 1, 20, 8, 8, 1, 100);
        add_step(0, 6, 6, 8'h30, lane_status(1, 0, 8'd210, 0), repair_off, 3, 4,
                 {7'b0000000, 8'hFF}, 4, 4, 1, 24, 8, 8, 1, 100);
        add_step(0, 32, 6, 8'h30, lane_status(1, 0, 8'd210, 0), repair_off, 3, 5,
                 {7'b0000000, 8'hFF}, 4, 4, 1, 24, 8, 8, 1, 100);

        for (int t = 0; t < 20 && !rst_n; t++) begin
            @(posedge clk);
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            for (int r = 0; r < steps.size(); r++) begin
                apply_step(steps[r]);
                check_valid <= 1'b0;
                for (int c = 0; c < steps[r].hold; c++) begin
                    @(posedge clk);
                end
                check_row   <= r;
                exp_step    <= steps[r];
                check_valid <= 1'b1;
                // Checker answers at the falling edge that follows
                for (int t = 0; t < 8; t++) begin
                    @(posedge clk);
                    if (rows_done == r + 1) begin
                        break;
                    end
                end
                if (rows_done != r + 1) begin
                    $display("Timeout: checker did not finish row %0d", r);
                    timed_out = 1'b1;
                    break;
                end
            end
        end

        lane_manager_checker_i.print_summary();
        if (timed_out || (error_total != 0)) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/lane_mgr_pkg.sv
hdl/lane_fsm.sv
hdl/lane_stats.sv
hdl/link_health.sv
hdl/lane_manager.sv
bench/tb_clock_gen.sv
bench/lane_manager_checker.sv
bench/lane_manager_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lane_manager_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run check clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

check:
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
